// ==== verilog/ex1Pkg.sv ====
// shared widths, micro-op and memory encodings, register ids and trap codes for the EX1 stage
package ex1Pkg;

	// datapath and virtual address widths
	localparam int xlen = 64;
	localparam int vaWidth = 48;

	// register id covers both GPR and control-register slots
	typedef logic [5:0] gprIdT;
	// bits 7..6 condition, bits 5..0 opcode
	typedef logic [7:0] uCmdT;
	// extension byte, meaning depends on opcode
	typedef logic [7:0] uIxtT;

	// condition codes
	localparam logic [1:0] ccAl = 2'd0;
	localparam logic [1:0] ccNv = 2'd1;
	localparam logic [1:0] ccCt = 2'd2;
	localparam logic [1:0] ccCf = 2'd3;

	// opcodes
	localparam logic [5:0] opNop = 6'h00;
	localparam logic [5:0] opInvOp = 6'h01;
	localparam logic [5:0] opLea = 6'h02;
	localparam logic [5:0] opMovRm = 6'h03;
	localparam logic [5:0] opMovMr = 6'h04;
	localparam logic [5:0] opAlu3 = 6'h05;
	localparam logic [5:0] opMovIr = 6'h06;
	localparam logic [5:0] opBra = 6'h07;
	localparam logic [5:0] opBraNb = 6'h08;
	localparam logic [5:0] opBsr = 6'h09;
	localparam logic [5:0] opJmp = 6'h0A;
	localparam logic [5:0] opJsr = 6'h0B;
	localparam logic [5:0] opShad3 = 6'h0C;
	localparam logic [5:0] opIxt = 6'h0D;

	// IXT sub-ops, carried in opUIxt bits 5..0
	localparam logic [5:0] ixtNop = 6'h00;
	localparam logic [5:0] ixtClrt = 6'h01;
	localparam logic [5:0] ixtSett = 6'h02;
	localparam logic [5:0] ixtNott = 6'h03;
	localparam logic [5:0] ixtClrs = 6'h04;
	localparam logic [5:0] ixtSets = 6'h05;
	localparam logic [5:0] ixtNots = 6'h06;
	localparam logic [5:0] ixtRte = 6'h07;
	localparam logic [5:0] ixtTrapa = 6'h08;

	// memory op, {class, extend, size}
	localparam logic [4:0] memOpmReady = 5'b00000;
	localparam logic [1:0] memOpLdPfx = 2'b01;
	localparam logic [1:0] memOpStPfx = 2'b10;

	// memory status from the load/store unit
	localparam logic [1:0] memOkReady = 2'd0;
	localparam logic [1:0] memOkOk = 2'd1;
	localparam logic [1:0] memOkHold = 2'd2;

	// register ids
	localparam gprIdT gprZzr = 6'h00;
	localparam gprIdT gprLr = 6'h01;
	// control-register slots
	localparam gprIdT crPc = 6'h20;
	localparam gprIdT crZzr = 6'h3F;

	// trap codes
	localparam logic [15:0] trapRte = 16'hFF00;
	// low nibble filled from the Rm id
	localparam logic [15:0] trapaBase = 16'hC080;

	// SR bit positions
	localparam int srT = 0;
	localparam int srS = 1;
	// jumbo-address mode, widens branch targets past 32 bits
	localparam int srJq = 31;

endpackage

// ==== verilog/ex1Predicate.sv ====
// predication front end of EX1, turns disabled or flushed micro-ops into NOP or BRA_NB
module ex1Predicate
	import ex1Pkg::*;
(
	input  uCmdT opUCmd,
	input  logic opBraFlush,
	input  logic srT,
	output uCmdT opUCmdOut
);

	logic opEnable;
	logic [5:0] opCode;
	logic [5:0] opSubst;
	logic [5:0] opEff;

	assign opCode = opUCmd[5:0];

	// condition field against SR.T
	always_comb begin
		case (opUCmd[7:6])
			ccAl: opEnable = 1'b1;
			ccNv: opEnable = 1'b0;
			ccCt: opEnable = srT;
			default: opEnable = !srT;
		endcase
		// flushed ops never run
		if (opBraFlush) begin
			opEnable = 1'b0;
		end
	end

	// not-taken branch still needs BRA_NB so a pre-branch can be undone
	assign opSubst = ((opCode == opBra) && !opBraFlush) ? opBraNb : opNop;
	assign opEff = opEnable ? opCode : opSubst;

	// condition already applied
	assign opUCmdOut = {ccAl, opEff};

	always_comb begin
		if (opBraFlush) begin
			assert (opUCmdOut[5:0] == opNop)
			else $error("flushed micro-op leaked as %h", opUCmdOut);
		end
	end

endmodule

// ==== verilog/ex1Agu.sv ====
// EX1 address generator that ex1Stage uses for the load/store address and the PC-relative branch target
module ex1Agu
	import ex1Pkg::*;
#(
	parameter int addrWidth = vaWidth
) (
	input  logic clock,
	input  logic [xlen-1:0] regValRs,
	input  logic [xlen-1:0] regValRt,
	input  logic [xlen-1:0] regValPc,
	input  uIxtT opUIxt,
	input  logic jqMode,
	output logic [addrWidth-1:0] memAddrCalc,
	output logic [xlen-1:0] braTarget
);

	logic [xlen-1:0] idxScaled;
	logic [xlen-1:0] addrSum;
	logic [47:0] braDisp;
	logic [16:0] laneA;
	logic [16:0] laneB0;
	logic [16:0] laneB1;
	logic [16:0] laneC0;
	logic [16:0] laneC1;
	logic [15:0] laneB;
	logic [15:0] laneC;
	logic carryB;
	logic [47:0] plainSum;

	// index scaled by access size
	assign idxScaled = regValRt << opUIxt[5:4];
	assign addrSum = regValRs + idxScaled;
	assign memAddrCalc = addrSum[addrWidth-1:0];

	// displacement counts 16-bit words
	assign braDisp = {regValRt[46:0], 1'b0};

	// low lane adds directly
	assign laneA = {1'b0, regValPc[15:0]} + {1'b0, braDisp[15:0]};
	// upper lanes precompute both carry-in cases
	assign laneB0 = {1'b0, regValPc[31:16]} + {1'b0, braDisp[31:16]};
	assign laneB1 = {1'b0, regValPc[31:16]} + {1'b0, braDisp[31:16]} + 17'd1;
	assign laneC0 = {1'b0, regValPc[47:32]} + {1'b0, braDisp[47:32]};
	assign laneC1 = {1'b0, regValPc[47:32]} + {1'b0, braDisp[47:32]} + 17'd1;

	// carry select chain
	assign laneB = laneA[16] ? laneB1[15:0] : laneB0[15:0];
	assign carryB = laneA[16] ? laneB1[16] : laneB0[16];
	assign laneC = carryB ? laneC1[15:0] : laneC0[15:0];

	// pc bits 63..48 kept and bits 47..32 only move in jumbo mode
	assign braTarget = {regValPc[63:48], jqMode ? laneC : regValPc[47:32], laneB, laneA[15:0]};

	// plain adder that the lane check compares against
	assign plainSum = regValPc[47:0] + braDisp;

	// lanes match one adder and outside jumbo mode a branch stays inside its 4GB region
	assert property (@(posedge clock)
		braTarget[47:0] == (jqMode ? plainSum : {regValPc[47:32], plainSum[31:0]}))
	else $error("branch target %h wrong for pc %h", braTarget, regValPc);

endmodule

// ==== verilog/ex1Shifter.sv ====
// merged 64/32-bit shifter for SHAD3, signed amount picks left or right
module ex1Shifter
	import ex1Pkg::*;
(
	input  logic [xlen-1:0] regValRs,
	input  logic [xlen-1:0] regValRt,
	input  uIxtT opUIxt,
	output logic [xlen-1:0] shiftVal
);

	logic signed [7:0] shAmt;
	logic [7:0] rightAmt;
	logic isArith;
	logic isWide;
	logic [xlen-1:0] opIn;
	logic [xlen-1:0] shRes;

	assign shAmt = regValRt[7:0];
	// magnitude of a negative amount, -128 maps to 128
	assign rightAmt = 8'(-shAmt);
	assign isArith = opUIxt[0];
	assign isWide = opUIxt[1];

	// 32-bit mode works on the extended low word
	always_comb begin
		if (isWide) begin
			opIn = regValRs;
		end else if (isArith) begin
			opIn = {{32{regValRs[31]}}, regValRs[31:0]};
		end else begin
			opIn = {32'h0, regValRs[31:0]};
		end
	end

	always_comb begin
		if (!shAmt[7]) begin
			shRes = opIn << shAmt[6:0];
		end else if (isArith) begin
			shRes = $signed(opIn) >>> rightAmt;
		end else begin
			shRes = opIn >> rightAmt;
		end
	end

	// narrow result re-extended by the same rule as the operand
	always_comb begin
		if (isWide) begin
			shiftVal = shRes;
		end else if (isArith) begin
			shiftVal = {{32{shRes[31]}}, shRes[31:0]};
		end else begin
			shiftVal = {32'h0, shRes[31:0]};
		end
	end

endmodule

// ==== verilog/ex1Dispatch.sv ====
// EX1 opcode decode, picks results, memory request, branch, SR, LR and trap outputs
module ex1Dispatch
	import ex1Pkg::*;
#(
	parameter int addrWidth = vaWidth
) (
	input  uCmdT opUCmdEff,
	input  uIxtT opUIxt,
	input  gprIdT regIdRs,
	input  gprIdT regIdRm,
	input  logic [xlen-1:0] regValRs,
	input  logic [xlen-1:0] regValRt,
	input  logic [xlen-1:0] regValRm,
	input  logic [xlen-1:0] regValPc,
	input  logic [xlen-1:0] regInSr,
	input  logic [xlen-1:0] regInLr,
	input  logic opBraFlush,
	input  logic opPreBra,
	input  logic [1:0] memOk,
	input  logic [addrWidth-1:0] memAddrCalc,
	input  logic [xlen-1:0] braTarget,
	input  logic [xlen-1:0] shiftVal,
	output logic exHold,
	output logic regHeld,
	output gprIdT heldIdRn,
	output gprIdT regIdRn,
	output logic [xlen-1:0] regValRn,
	output gprIdT regIdCn,
	output logic [xlen-1:0] regValCn,
	output logic [xlen-1:0] regOutSr,
	output logic [xlen-1:0] regOutLr,
	output logic [addrWidth-1:0] memAddr,
	output logic [4:0] memOpm,
	output logic [xlen-1:0] memDataOut,
	output logic [15:0] exTrapExc
);

	logic [5:0] opCode;
	logic doOut;
	logic [xlen-1:0] outVal;
	logic doMem;
	logic [4:0] memOpmSel;
	logic doBra;
	logic [xlen-1:0] braVal;
	logic [xlen-1:0] jumpVal;

	// condition field is already resolved upstream
	assign opCode = opUCmdEff[5:0];

	// address and store data always presented, memOpm qualifies them
	assign memAddr = memAddrCalc;
	assign memDataOut = regValRm;
	assign heldIdRn = regHeld ? regIdRm : gprZzr;

	// register jump keeps pc upper bits
	always_comb begin
		jumpVal = {regValPc[63:48], regValRs[47:0]};
		// return through LR restores saved upper bits too
		if (regIdRs == gprLr) begin
			jumpVal[63:48] = regValRs[63:48];
		end
	end

	always_comb begin
		doOut = 1'b0;
		outVal = '0;
		doMem = 1'b0;
		memOpmSel = memOpmReady;
		doBra = 1'b0;
		braVal = braTarget;
		exHold = 1'b0;
		regHeld = 1'b0;
		regOutSr = regInSr;
		regOutLr = regInLr;
		exTrapExc = '0;
		regIdRn = gprZzr;
		regValRn = '0;
		regIdCn = crZzr;
		regValCn = '0;
		memOpm = memOpmReady;

		case (opCode)
			opNop: begin
				// nothing to do
			end
			// stall until something upstream sorts it out
			opInvOp: exHold = 1'b1;
			opLea: begin
				doOut = 1'b1;
				outVal = xlen'(memAddrCalc);
			end
			opMovRm: begin
				doMem = 1'b1;
				memOpmSel = {memOpStPfx, opUIxt[2], opUIxt[5:4]};
			end
			opMovMr: begin
				doMem = 1'b1;
				memOpmSel = {memOpLdPfx, opUIxt[2], opUIxt[5:4]};
				// load data lands in a later stage
				regHeld = 1'b1;
			end
			opAlu3: regHeld = 1'b1;
			opMovIr: begin
				doOut = 1'b1;
				// constant shifted in below rs
				case (opUIxt[3:0])
					4'h1: outVal = {regValRs[55:0], regValRt[7:0]};
					4'h2: outVal = {regValRs[47:0], regValRt[15:0]};
					4'h3: outVal = {regValRs[31:0], regValRt[31:0]};
					default: outVal = regValRt;
				endcase
			end
			// pre-branch already taken by fetch
			opBra: doBra = !opPreBra;
			opBraNb: begin
				// undo a wrong pre-branch
				doBra = opPreBra;
				braVal = regValPc;
			end
			opBsr: begin
				regOutLr = regValPc;
				doBra = !opPreBra;
			end
			opJmp: begin
				braVal = jumpVal;
				doBra = !opPreBra;
			end
			opJsr: begin
				regOutLr = regValPc;
				braVal = jumpVal;
				doBra = 1'b1;
			end
			opShad3: begin
				doOut = 1'b1;
				outVal = shiftVal;
			end
			opIxt: begin
				case (opUIxt[5:0])
					ixtNop: begin
						// no effect
					end
					ixtClrt: regOutSr[srT] = 1'b0;
					ixtSett: regOutSr[srT] = 1'b1;
					ixtNott: regOutSr[srT] = !regInSr[srT];
					ixtClrs: regOutSr[srS] = 1'b0;
					ixtSets: regOutSr[srS] = 1'b1;
					ixtNots: regOutSr[srS] = !regInSr[srS];
					ixtRte: exTrapExc = trapRte;
					ixtTrapa: exTrapExc = {trapaBase[15:4], regIdRm[3:0]};
					default: exHold = 1'b1;
				endcase
			end
			default: exHold = 1'b1;
		endcase

		// single-cycle results go to Rm
		if (doOut) begin
			regIdRn = regIdRm;
			regValRn = outVal;
		end
		// memory back-pressure
		if (doMem) begin
			memOpm = memOpmSel;
			if (memOk == memOkHold) begin
				exHold = 1'b1;
			end
		end
		if (doBra) begin
			regIdCn = crPc;
			regValCn = braVal;
		end
		// flushed op writes nothing
		if (opBraFlush) begin
			regIdRn = gprZzr;
			regIdCn = crZzr;
		end
	end

	always_comb begin
		if (memOpm != memOpmReady) begin
			assert ((opCode == opMovRm) || (opCode == opMovMr))
			else $error("memory op %h issued by opcode %h", memOpm, opCode);
		end
	end

endmodule

// ==== verilog/ex1Stage.sv ====
// EX1 pipeline stage top, ties predication, AGU, shifter and dispatch around the jumbo-mode flop
module ex1Stage
	import ex1Pkg::*;
#(
	parameter int addrWidth = vaWidth
) (
	input  logic clock,
	input  logic rst,
	input  uCmdT opUCmd,
	input  uIxtT opUIxt,
	input  gprIdT regIdRs,
	input  gprIdT regIdRm,
	input  logic [xlen-1:0] regValRs,
	input  logic [xlen-1:0] regValRt,
	input  logic [xlen-1:0] regValRm,
	input  logic [xlen-1:0] regValPc,
	input  logic [xlen-1:0] regInSr,
	input  logic [xlen-1:0] regInLr,
	input  logic opBraFlush,
	input  logic opPreBra,
	input  logic [1:0] memOk,
	output uCmdT opUCmdOut,
	output logic exHold,
	output logic regHeld,
	output gprIdT heldIdRn,
	output gprIdT regIdRn,
	output logic [xlen-1:0] regValRn,
	output gprIdT regIdCn,
	output logic [xlen-1:0] regValCn,
	output logic [xlen-1:0] regOutSr,
	output logic [xlen-1:0] regOutLr,
	output logic [addrWidth-1:0] memAddr,
	output logic [4:0] memOpm,
	output logic [xlen-1:0] memDataOut,
	output logic [15:0] exTrapExc
);

	logic jqMode;
	logic [addrWidth-1:0] memAddrCalc;
	logic [xlen-1:0] braTarget;
	logic [xlen-1:0] shiftVal;

	// SR.JQ seen one cycle late, off the AGU critical path
	always_ff @(posedge clock) begin
		if (rst) begin
			jqMode <= 1'b0;
		end else begin
			jqMode <= regInSr[srJq];
		end
	end

	ex1Predicate pred (
		.opUCmd(opUCmd),
		.opBraFlush(opBraFlush),
		.srT(regInSr[srT]),
		.opUCmdOut(opUCmdOut)
	);

	ex1Agu #(.addrWidth(addrWidth)) agu (
		.clock(clock),
		.regValRs(regValRs),
		.regValRt(regValRt),
		.regValPc(regValPc),
		.opUIxt(opUIxt),
		.jqMode(jqMode),
		.memAddrCalc(memAddrCalc),
		.braTarget(braTarget)
	);

	ex1Shifter shifter (
		.regValRs(regValRs),
		.regValRt(regValRt),
		.opUIxt(opUIxt),
		.shiftVal(shiftVal)
	);

	ex1Dispatch #(.addrWidth(addrWidth)) dispatch (
		.opUCmdEff(opUCmdOut), .opUIxt(opUIxt),
		.regIdRs(regIdRs), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt),
		.regValRm(regValRm), .regValPc(regValPc),
		.regInSr(regInSr), .regInLr(regInLr),
		.opBraFlush(opBraFlush), .opPreBra(opPreBra), .memOk(memOk),
		.memAddrCalc(memAddrCalc), .braTarget(braTarget), .shiftVal(shiftVal),
		.exHold(exHold), .regHeld(regHeld), .heldIdRn(heldIdRn),
		.regIdRn(regIdRn), .regValRn(regValRn),
		.regIdCn(regIdCn), .regValCn(regValCn),
		.regOutSr(regOutSr), .regOutLr(regOutLr),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.exTrapExc(exTrapExc)
	);

	// a flushed op must be fully inert across predication and dispatch
	assert property (@(posedge clock) disable iff (rst)
		opBraFlush |-> (regIdRn == gprZzr) && (regIdCn == crZzr) && !exHold
			&& (memOpm == memOpmReady) && (exTrapExc == 16'h0))
	else $error("flushed op still active, cmd %h", opUCmd);

endmodule

// ==== include/ex1TbModel.svh ====
// reference functions that the EX1 testbench includes inside its module after importing ex1Pkg
`ifndef EX1_TB_MODEL_SVH
`define EX1_TB_MODEL_SVH

// expected opUCmdOut
function automatic uCmdT predicatedCmd(input uCmdT cmd, input logic flush, input logic t);
	logic run;
	run = !flush && ((cmd[7:6] == ccAl) || ((cmd[7:6] == ccCt) && t)
		|| ((cmd[7:6] == ccCf) && !t));
	if (run) begin
		return {ccAl, cmd[5:0]};
	end
	return {ccAl, ((cmd[5:0] == opBra) && !flush) ? opBraNb : opNop};
endfunction

// full-width load/store address that the caller truncates
function automatic logic [xlen-1:0] scaledAddress(input logic [xlen-1:0] rs,
	input logic [xlen-1:0] rt, input uIxtT ixt);
	return rs + (rt << ixt[5:4]);
endfunction

// pc-relative target from one plain adder
function automatic logic [xlen-1:0] pcRelTarget(input logic [xlen-1:0] pc,
	input logic [xlen-1:0] rt, input logic jq);
	logic [xlen-1:0] sum;
	sum = pc + {rt[62:0], 1'b0};
	return {pc[63:48], jq ? sum[47:32] : pc[47:32], sum[31:0]};
endfunction

function automatic logic [xlen-1:0] regJumpTarget(input logic [xlen-1:0] pc,
	input logic [xlen-1:0] rs, input logic fromLr);
	return {fromLr ? rs[63:48] : pc[63:48], rs[47:0]};
endfunction

// bit-serial shift moving one position per step
function automatic logic [xlen-1:0] serialShift(input logic [xlen-1:0] rs,
	input logic [xlen-1:0] rt, input uIxtT ixt);
	logic [xlen-1:0] v;
	int amt;
	amt = int'($signed(rt[7:0]));
	v = ixt[1] ? rs : {{32{ixt[0] & rs[31]}}, rs[31:0]};
	for (int i = 0; i < 128; i++) begin
		if (i < amt) begin
			v = {v[62:0], 1'b0};
		end else if (i < -amt) begin
			v = {ixt[0] & v[63], v[63:1]};
		end
	end
	return ixt[1] ? v : {{32{ixt[0] & v[31]}}, v[31:0]};
endfunction

// SR after an IXT flag op
function automatic logic [xlen-1:0] flagOpSr(input logic [xlen-1:0] sr, input logic [5:0] sub);
	logic [xlen-1:0] r;
	r = sr;
	case (sub)
		ixtClrt: r[srT] = 1'b0;
		ixtSett: r[srT] = 1'b1;
		ixtNott: r[srT] = !sr[srT];
		ixtClrs: r[srS] = 1'b0;
		ixtSets: r[srS] = 1'b1;
		ixtNots: r[srS] = !sr[srS];
		default: r = sr;
	endcase
	return r;
endfunction

// trap code for an effective opcode
function automatic logic [15:0] trapCodeFor(input logic [5:0] op, input logic [5:0] sub,
	input gprIdT idRm);
	if ((op == opIxt) && (sub == ixtRte)) begin
		return trapRte;
	end
	if ((op == opIxt) && (sub == ixtTrapa)) begin
		return {trapaBase[15:4], idRm[3:0]};
	end
	return 16'h0;
endfunction

`endif

// ==== sim/ex1Tb.sv ====
// simulation top that drives directed and random micro-ops into ex1Stage and checks them by assertions
module ex1Tb
	import ex1Pkg::*;
;

	`include "ex1TbModel.svh"

	localparam int addrW = vaWidth;
	localparam int cycleLimit = 5000;

	// check indices into errCnt
	localparam int cPred = 0;
	localparam int cRn = 1;
	localparam int cHeld = 2;
	localparam int cOpm = 3;
	localparam int cBus = 4;
	localparam int cHold = 5;
	localparam int cCn = 6;
	localparam int cLr = 7;
	localparam int cSr = 8;
	localparam int cTrap = 9;
	localparam int cWait = 10;

	logic clock;
	logic rst;
	uCmdT opUCmd;
	uIxtT opUIxt;
	gprIdT regIdRs;
	gprIdT regIdRm;
	logic [xlen-1:0] regValRs;
	logic [xlen-1:0] regValRt;
	logic [xlen-1:0] regValRm;
	logic [xlen-1:0] regValPc;
	logic [xlen-1:0] regInSr;
	logic [xlen-1:0] regInLr;
	logic opBraFlush;
	logic opPreBra;
	logic [1:0] memOk;
	uCmdT opUCmdOut;
	logic exHold;
	logic regHeld;
	gprIdT heldIdRn;
	gprIdT regIdRn;
	logic [xlen-1:0] regValRn;
	gprIdT regIdCn;
	logic [xlen-1:0] regValCn;
	logic [xlen-1:0] regOutSr;
	logic [xlen-1:0] regOutLr;
	logic [addrW-1:0] memAddr;
	logic [4:0] memOpm;
	logic [xlen-1:0] memDataOut;
	logic [15:0] exTrapExc;

	int errCnt [11];
	logic [31:0] lfsrState = 32'hbf9729c7;

	// expected values
	uCmdT expCmd;
	logic [5:0] effOp;
	logic isLoad;
	logic isStore;
	logic jqPrev;
	logic [addrW-1:0] expAddr;
	gprIdT expIdRn;
	logic [xlen-1:0] expValRn;
	logic expHeld;
	gprIdT expHeldId;
	logic [4:0] expOpm;
	logic expHold;
	gprIdT expIdCn;
	logic [xlen-1:0] expValCn;
	logic [xlen-1:0] expLr;
	logic [xlen-1:0] expSr;
	logic [15:0] expTrap;

	ex1Stage #(.addrWidth(addrW)) UUT (
		.clock(clock), .rst(rst), .opUCmd(opUCmd), .opUIxt(opUIxt),
		.regIdRs(regIdRs), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt),
		.regValRm(regValRm), .regValPc(regValPc),
		.regInSr(regInSr), .regInLr(regInLr),
		.opBraFlush(opBraFlush), .opPreBra(opPreBra), .memOk(memOk),
		.opUCmdOut(opUCmdOut), .exHold(exHold), .regHeld(regHeld), .heldIdRn(heldIdRn),
		.regIdRn(regIdRn), .regValRn(regValRn), .regIdCn(regIdCn), .regValCn(regValCn),
		.regOutSr(regOutSr), .regOutLr(regOutLr),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.exTrapExc(exTrapExc)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [63:0] randBits(input int n);
		logic [63:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic logic [5:0] opFromIndex(input int idx);
		case (idx)
			0: return opNop;
			1: return opInvOp;
			2: return opLea;
			3: return opMovRm;
			4: return opMovMr;
			5: return opAlu3;
			6: return opMovIr;
			7: return opBra;
			8: return opBraNb;
			9: return opBsr;
			10: return opJmp;
			11: return opJsr;
			12: return opShad3;
			default: return opIxt;
		endcase
	endfunction

	// IXT only gets defined sub-ops
	function automatic uIxtT ixtFor(input logic [5:0] op);
		uIxtT x;
		x = uIxtT'(randBits(8));
		if (op == opIxt) begin
			x[5:0] = 6'(int'(randBits(4)) % 9);
		end
		return x;
	endfunction

	// LDI and LDISHn with rt filling the vacated low bits
	function automatic logic [xlen-1:0] ldiValue(input logic [xlen-1:0] rs,
		input logic [xlen-1:0] rt, input logic [3:0] form);
		int n;
		case (form)
			4'd1: n = 8;
			4'd2: n = 16;
			4'd3: n = 32;
			default: n = 0;
		endcase
		if (n == 0) begin
			return rt;
		end
		return (rs << n) | (rt & ((64'd1 << n) - 64'd1));
	endfunction

	// jumbo mode as seen by the branch adder
	always @(posedge clock) begin
		jqPrev <= rst ? 1'b0 : regInSr[srJq];
	end

	always_comb begin
		expCmd = predicatedCmd(opUCmd, opBraFlush, regInSr[srT]);
		effOp = expCmd[5:0];
		isLoad = effOp == opMovMr;
		isStore = effOp == opMovRm;
		expAddr = addrW'(scaledAddress(regValRs, regValRt, opUIxt));
		expHeld = (effOp == opAlu3) || isLoad;
		expHeldId = expHeld ? regIdRm : gprZzr;
		expHold = (effOp == opInvOp) || ((isLoad || isStore) && (memOk == memOkHold));
		expSr = (effOp == opIxt) ? flagOpSr(regInSr, opUIxt[5:0]) : regInSr;
		expTrap = trapCodeFor(effOp, opUIxt[5:0], regIdRm);
		if (isLoad) begin
			expOpm = {memOpLdPfx, opUIxt[2], opUIxt[5:4]};
		end else if (isStore) begin
			expOpm = {memOpStPfx, opUIxt[2], opUIxt[5:4]};
		end else begin
			expOpm = memOpmReady;
		end
	end

	// Rm results
	always_comb begin
		expIdRn = gprZzr;
		expValRn = '0;
		case (effOp)
			opLea: begin
				expIdRn = regIdRm;
				expValRn = xlen'(expAddr);
			end
			opMovIr: begin
				expIdRn = regIdRm;
				expValRn = ldiValue(regValRs, regValRt, opUIxt[3:0]);
			end
			opShad3: begin
				expIdRn = regIdRm;
				expValRn = serialShift(regValRs, regValRt, opUIxt);
			end
			default: ;
		endcase
		if (opBraFlush) begin
			expIdRn = gprZzr;
		end
	end

	// branch and link
	always_comb begin
		expIdCn = crZzr;
		expValCn = '0;
		expLr = regInLr;
		case (effOp)
			opBra, opBsr: begin
				if (!opPreBra) begin
					expIdCn = crPc;
					expValCn = pcRelTarget(regValPc, regValRt, jqPrev);
				end
			end
			opBraNb: begin
				if (opPreBra) begin
					expIdCn = crPc;
					expValCn = regValPc;
				end
			end
			opJmp: begin
				if (!opPreBra) begin
					expIdCn = crPc;
					expValCn = regJumpTarget(regValPc, regValRs, regIdRs == gprLr);
				end
			end
			opJsr: begin
				expIdCn = crPc;
				expValCn = regJumpTarget(regValPc, regValRs, regIdRs == gprLr);
			end
			default: ;
		endcase
		if ((effOp == opBsr) || (effOp == opJsr)) begin
			expLr = regValPc;
		end
		if (opBraFlush) begin
			expIdCn = crZzr;
		end
	end

	assert property (@(posedge clock) disable iff (rst) opUCmdOut == expCmd)
	else begin
		errCnt[cPred]++;
		$display("ERR opUCmdOut got %h exp %h", $sampled(opUCmdOut), $sampled(expCmd));
	end

	assert property (@(posedge clock) disable iff (rst)
		(regIdRn == expIdRn) && ((expIdRn == gprZzr) || (regValRn == expValRn)))
	else begin
		errCnt[cRn]++;
		$display("ERR regIdRn got %h exp %h regValRn got %h exp %h", $sampled(regIdRn),
			$sampled(expIdRn), $sampled(regValRn), $sampled(expValRn));
	end

	assert property (@(posedge clock) disable iff (rst)
		(regHeld == expHeld) && (heldIdRn == expHeldId))
	else begin
		errCnt[cHeld]++;
		$display("ERR regHeld got %h exp %h heldIdRn got %h exp %h", $sampled(regHeld),
			$sampled(expHeld), $sampled(heldIdRn), $sampled(expHeldId));
	end

	assert property (@(posedge clock) disable iff (rst) memOpm == expOpm)
	else begin
		errCnt[cOpm]++;
		$display("ERR memOpm got %h exp %h", $sampled(memOpm), $sampled(expOpm));
	end

	// address and data only matter with a request out
	assert property (@(posedge clock) disable iff (rst)
		(expOpm != memOpmReady) |-> (memAddr == expAddr) && (memDataOut == regValRm))
	else begin
		errCnt[cBus]++;
		$display("ERR memAddr got %h exp %h memDataOut got %h exp %h", $sampled(memAddr),
			$sampled(expAddr), $sampled(memDataOut), $sampled(regValRm));
	end

	assert property (@(posedge clock) disable iff (rst) exHold == expHold)
	else begin
		errCnt[cHold]++;
		$display("ERR exHold got %h exp %h", $sampled(exHold), $sampled(expHold));
	end

	assert property (@(posedge clock) disable iff (rst)
		(regIdCn == expIdCn) && ((expIdCn != crPc) || (regValCn == expValCn)))
	else begin
		errCnt[cCn]++;
		$display("ERR regIdCn got %h exp %h regValCn got %h exp %h", $sampled(regIdCn),
			$sampled(expIdCn), $sampled(regValCn), $sampled(expValCn));
	end

	assert property (@(posedge clock) disable iff (rst) regOutLr == expLr)
	else begin
		errCnt[cLr]++;
		$display("ERR regOutLr got %h exp %h", $sampled(regOutLr), $sampled(expLr));
	end

	assert property (@(posedge clock) disable iff (rst) regOutSr == expSr)
	else begin
		errCnt[cSr]++;
		$display("ERR regOutSr got %h exp %h", $sampled(regOutSr), $sampled(expSr));
	end

	assert property (@(posedge clock) disable iff (rst) exTrapExc == expTrap)
	else begin
		errCnt[cTrap]++;
		$display("ERR exTrapExc got %h exp %h", $sampled(exTrapExc), $sampled(expTrap));
	end

	// one micro-op per cycle with operands from the LFSR
	task automatic applyOp(input uCmdT cmd, input uIxtT ixt, input logic [1:0] ok);
		@(posedge clock);
		opUCmd <= cmd;
		opUIxt <= ixt;
		regIdRs <= (randBits(1) == 64'd1) ? gprLr : gprIdT'(randBits(6));
		regIdRm <= gprIdT'(randBits(6));
		regValRs <= randBits(64);
		regValRt <= randBits(64);
		regValRm <= randBits(64);
		regValPc <= randBits(64);
		regInSr <= randBits(64);
		regInLr <= randBits(64);
		opBraFlush <= randBits(3) == 64'd0;
		opPreBra <= randBits(1) == 64'd1;
		memOk <= ok;
	endtask

	task automatic waitHoldLow(input int limit);
		int n;
		n = 0;
		@(negedge clock);
		while (exHold && (n < limit)) begin
			@(negedge clock);
			n++;
		end
		if (exHold) begin
			errCnt[cWait]++;
			$display("exHold stayed high %0d cycles after the memory released", limit);
		end
	endtask

	// load or store held off by the memory and then released
	task automatic stallMem(input logic [5:0] op, input int holdCycles);
		applyOp({ccAl, op}, uIxtT'(randBits(8)), memOkHold);
		opBraFlush <= 1'b0;
		repeat (holdCycles) @(posedge clock);
		memOk <= memOkOk;
		waitHoldLow(8);
	endtask

	// watchdog
	initial begin
		for (int i = 0; i < cycleLimit; i++) begin
			@(posedge clock);
		end
		$display("simulation ran past %0d cycles", cycleLimit);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [5:0] op;
		int total;
		rst <= 1'b1;
		opUCmd <= {ccAl, opNop};
		opUIxt <= '0;
		regIdRs <= gprZzr;
		regIdRm <= gprZzr;
		regValRs <= '0;
		regValRt <= '0;
		regValRm <= '0;
		regValPc <= '0;
		regInSr <= '0;
		regInLr <= '0;
		opBraFlush <= 1'b0;
		opPreBra <= 1'b0;
		memOk <= memOkReady;
		for (int i = 0; i < 16; i++) begin
			@(posedge clock);
		end
		rst <= 1'b0;

		// every opcode under every condition
		for (int cc = 0; cc < 4; cc++) begin
			for (int i = 0; i < 14; i++) begin
				op = opFromIndex(i);
				if (op == opIxt) begin
					for (int s = 0; s < 9; s++) begin
						applyOp({2'(cc), op}, {2'b00, 6'(s)}, 2'(randBits(2)));
					end
				end else if (op == opMovIr) begin
					for (int f = 0; f < 4; f++) begin
						applyOp({2'(cc), op}, {4'(randBits(4)), 4'(f)}, 2'(randBits(2)));
					end
				end else begin
					applyOp({2'(cc), op}, ixtFor(op), 2'(randBits(2)));
				end
			end
		end

		for (int i = 0; i < 4; i++) begin
			stallMem((i % 2 == 0) ? opMovMr : opMovRm, i + 1);
		end

		// random mix
		for (int i = 0; i < 600; i++) begin
			op = opFromIndex(int'(randBits(4)) % 14);
			applyOp({2'(randBits(2)), op}, ixtFor(op), 2'(randBits(2)));
		end

		applyOp({ccAl, opNop}, '0, memOkReady);
		repeat (2) @(posedge clock);

		total = 0;
		foreach (errCnt[i]) begin
			total += errCnt[i];
		end
		$write("error counts pred %0d rn %0d held %0d opm %0d bus %0d hold %0d",
			errCnt[cPred], errCnt[cRn], errCnt[cHeld], errCnt[cOpm], errCnt[cBus],
			errCnt[cHold]);
		$display(" cn %0d lr %0d sr %0d trap %0d wait %0d",
			errCnt[cCn], errCnt[cLr], errCnt[cSr], errCnt[cTrap], errCnt[cWait]);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+include
verilog/ex1Pkg.sv
verilog/ex1Predicate.sv
verilog/ex1Agu.sv
verilog/ex1Shifter.sv
verilog/ex1Dispatch.sv
verilog/ex1Stage.sv
sim/ex1Tb.sv

// ==== Makefile ====
# Verilator build and run for the EX1 stage testbench

VERILATOR ?= verilator
TOP ?= ex1Tb
BUILD ?= obj_dir
VFLAGS ?= --binary --assert -j 0
FILELIST ?= list.f
PASS_MSG ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/ex1TbModel.svh
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# simulator binary, rebuilt only when a source or the file list changes
$(BUILD)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD) -o V$*

# pass only when the pass message shows up as a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
